/* source/lsu_pkg.sv */
package lsu_pkg;

  // Datapath widths
  localparam int xlen = 32;
  localparam int xbytes = xlen / 8;

  // Direct-mapped L1D with one word per line
  localparam int l1d_index_bits = 4;
  localparam int l1d_lines = 2 ** l1d_index_bits;
  localparam int l1d_tag_bits = xlen - l1d_index_bits - 2;

  // Load op codes on load_op
  localparam logic [4:0] alu_lb = 5'h08;
  localparam logic [4:0] alu_lbu = 5'h09;
  localparam logic [4:0] alu_lh = 5'h0a;
  localparam logic [4:0] alu_lhu = 5'h0b;
  localparam logic [4:0] alu_lw = 5'h0c;

  // Store op codes on store_op
  localparam logic [4:0] alu_sb = 5'h10;
  localparam logic [4:0] alu_sh = 5'h11;
  localparam logic [4:0] alu_sw = 5'h12;

  // The one cacheable region, limit exclusive
  localparam logic [xlen-1:0] cacheable_base = 32'h8000_0000;
  localparam logic [xlen-1:0] cacheable_limit = 32'h8800_0000;

  // Store buffer
  localparam int sb_depth = 4;
  localparam int sb_ptr_bits = $clog2(sb_depth);

  // Load FSM states
  localparam logic [1:0] ld_accept = 2'd0;
  localparam logic [1:0] ld_bus_wait = 2'd1;
  localparam logic [1:0] ld_done = 2'd2;

  function automatic logic is_cacheable(input logic [xlen-1:0] addr);
    return (addr >= cacheable_base) && (addr < cacheable_limit);
  endfunction

endpackage

/* source/store_buffer.sv */
`timescale 1ns/1ps

module store_buffer (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               store_valid,
  input  logic [lsu_pkg::xlen-1:0]           store_addr,
  input  logic [lsu_pkg::xlen-1:0]           store_data,
  input  logic [4:0]                         store_op,
  input  logic                               load_valid,
  input  logic [lsu_pkg::xlen-1:0]           load_addr,
  input  logic                               bus_bvalid,
  output logic                               sb_full,
  output logic                               bus_awvalid,
  output logic [lsu_pkg::xlen-1:0]           bus_awaddr,
  output logic [lsu_pkg::xlen-1:0]           bus_wdata,
  output logic [lsu_pkg::xbytes-1:0]         bus_wstrb,
  output logic                               cache_wvalid,
  output logic [lsu_pkg::xlen-1:0]           cache_waddr,
  output logic [lsu_pkg::xlen-1:0]           cache_wdata,
  output logic [4:0]                         cache_wop,
  output logic                               rvalid,
  output logic                               load_in_sq,
  output logic [lsu_pkg::xlen-1:0]           sq_wdata
);

  logic [lsu_pkg::xlen-3:0]     entry_word [lsu_pkg::sb_depth];
  logic [lsu_pkg::xlen-1:0]     entry_data [lsu_pkg::sb_depth];
  logic [lsu_pkg::xbytes-1:0]   entry_strb [lsu_pkg::sb_depth];
  logic [4:0]                   entry_op [lsu_pkg::sb_depth];

  logic [lsu_pkg::sb_ptr_bits-1:0] head;
  logic [lsu_pkg::sb_ptr_bits-1:0] tail;
  logic [lsu_pkg::sb_ptr_bits:0]   count;
  logic                            draining;
  logic                            push;
  logic                            pop;

  logic [lsu_pkg::xbytes-1:0] store_strb;
  logic [lsu_pkg::xlen-1:0]   store_lane_data;

  logic                       match;
  logic                       match_full;
  logic [lsu_pkg::xlen-1:0]   match_data;
  logic                       forward;

  assign sb_full = count == (lsu_pkg::sb_ptr_bits + 1)'(lsu_pkg::sb_depth);
  assign push = store_valid && !sb_full;
  assign pop = draining && bus_bvalid;

  // Byte lanes of the incoming store
  always_comb begin
    case (store_op)
      lsu_pkg::alu_sb: store_strb = 4'b0001 << store_addr[1:0];
      lsu_pkg::alu_sh: store_strb = 4'b0011 << store_addr[1:0];
      lsu_pkg::alu_sw: store_strb = 4'b1111;
      default:         store_strb = 4'b1111;
    endcase
  end

  assign store_lane_data = store_data << {store_addr[1:0], 3'b000};

  always_ff @(posedge clock) begin
    if (push) begin
      entry_word[tail] <= store_addr[lsu_pkg::xlen-1:2];
      entry_data[tail] <= store_lane_data;
      entry_strb[tail] <= store_strb;
      entry_op[tail] <= store_op;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      draining <= 1'b0;
      cache_wvalid <= 1'b0;
    end else begin
      cache_wvalid <= 1'b0;
      if (push) begin
        tail <= tail + 1'b1;
      end
      if (pop) begin
        head <= head + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Head entry is held on the bus until the write response
      if (pop) begin
        draining <= 1'b0;
      end else if (!draining && count != '0) begin
        draining <= 1'b1;
        cache_wvalid <= 1'b1;
      end
    end
  end

  assign bus_awvalid = draining;
  assign bus_awaddr = {entry_word[head], 2'b00};
  assign bus_wdata = entry_data[head];
  assign bus_wstrb = entry_strb[head];

  assign cache_waddr = {entry_word[head], 2'b00};
  assign cache_wdata = entry_data[head];
  assign cache_wop = entry_op[head];

  // Youngest queued store to the load's word wins
  always_comb begin
    logic [lsu_pkg::sb_ptr_bits-1:0] slot;
    match = 1'b0;
    match_full = 1'b0;
    match_data = '0;
    slot = head;
    for (int i = 0; i < lsu_pkg::sb_depth; i++) begin
      if (i < count && entry_word[slot] == load_addr[lsu_pkg::xlen-1:2]) begin
        match = 1'b1;
        match_full = entry_op[slot] == lsu_pkg::alu_sw;
        match_data = entry_data[slot];
      end
      slot = slot + 1'b1;
    end
  end

  // Uncacheable or partial matches wait for the store to reach memory
  assign forward = match && match_full && lsu_pkg::is_cacheable(load_addr);
  assign load_in_sq = load_valid && forward;
  assign rvalid = load_valid && !(match && !forward);
  assign sq_wdata = match_data;

endmodule

/* source/lsu_l1d.sv */
`timescale 1ns/1ps

module lsu_l1d (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         fence,
  input  logic                         rvalid,
  input  logic [lsu_pkg::xlen-1:0]     raddr,
  input  logic [4:0]                   ralu,
  input  logic                         load_in_sq,
  input  logic [lsu_pkg::xlen-1:0]     sq_wdata,
  input  logic                         wvalid,
  input  logic [lsu_pkg::xlen-1:0]     waddr,
  input  logic [lsu_pkg::xlen-1:0]     wdata,
  input  logic [4:0]                   walu,
  input  logic                         bus_rvalid,
  input  logic [lsu_pkg::xlen-1:0]     bus_rdata,
  output logic [lsu_pkg::xlen-1:0]     lsu_rdata,
  output logic                         lsu_rready,
  output logic                         bus_arvalid,
  output logic [lsu_pkg::xlen-1:0]     bus_araddr,
  output logic [lsu_pkg::xbytes-1:0]   bus_rstrb
);

  logic [lsu_pkg::xlen-1:0]         l1d_data [lsu_pkg::l1d_lines];
  logic [lsu_pkg::l1d_tag_bits-1:0] l1d_tag [lsu_pkg::l1d_lines];
  logic [lsu_pkg::l1d_lines-1:0]    l1d_valid;

  logic [1:0] state;

  // Load address fields
  logic [lsu_pkg::l1d_tag_bits-1:0]   addr_tag;
  logic [lsu_pkg::l1d_index_bits-1:0] addr_idx;
  logic                               cache_hit;
  logic                               cacheable;
  logic [lsu_pkg::xbytes-1:0]         lane_strb;

  // Store address fields
  logic [lsu_pkg::l1d_tag_bits-1:0]   waddr_tag;
  logic [lsu_pkg::l1d_index_bits-1:0] waddr_idx;
  logic                               w_hit;
  logic                               w_full;
  logic                               w_cacheable;

  // Array update, written on the next edge
  logic                               store_upd;
  logic                               refill_upd;
  logic                               upd;
  logic [lsu_pkg::xlen-1:0]           upd_data;
  logic                               upd_valid;
  logic [lsu_pkg::l1d_tag_bits-1:0]   upd_tag;
  logic [lsu_pkg::l1d_index_bits-1:0] upd_idx;

  assign addr_tag = raddr[lsu_pkg::xlen-1:lsu_pkg::l1d_index_bits+2];
  assign addr_idx = raddr[lsu_pkg::l1d_index_bits+1:2];
  assign cache_hit = l1d_valid[addr_idx] && (l1d_tag[addr_idx] == addr_tag);
  assign cacheable = lsu_pkg::is_cacheable(raddr);

  assign waddr_tag = waddr[lsu_pkg::xlen-1:lsu_pkg::l1d_index_bits+2];
  assign waddr_idx = waddr[lsu_pkg::l1d_index_bits+1:2];
  assign w_hit = l1d_valid[waddr_idx] && (l1d_tag[waddr_idx] == waddr_tag);
  assign w_full = walu == lsu_pkg::alu_sw;
  assign w_cacheable = lsu_pkg::is_cacheable(waddr);

  always_comb begin
    case (ralu)
      lsu_pkg::alu_lb,
      lsu_pkg::alu_lbu: lane_strb = 4'b0001 << raddr[1:0];
      lsu_pkg::alu_lh,
      lsu_pkg::alu_lhu: lane_strb = 4'b0011 << raddr[1:0];
      lsu_pkg::alu_lw:  lane_strb = 4'b1111;
      default:          lane_strb = 4'b1111;
    endcase
  end

  // Refills need the whole word
  assign bus_rstrb = cacheable ? 4'b1111 : lane_strb;
  assign bus_araddr = raddr;
  assign bus_arvalid = state == lsu_pkg::ld_bus_wait;
  assign lsu_rready = state == lsu_pkg::ld_done;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= lsu_pkg::ld_accept;
    end else begin
      case (state)
        lsu_pkg::ld_accept: begin
          if (rvalid) begin
            if (load_in_sq || cache_hit) begin
              state <= lsu_pkg::ld_done;
            end else begin
              state <= lsu_pkg::ld_bus_wait;
            end
          end
        end
        lsu_pkg::ld_bus_wait: begin
          if (bus_rvalid) begin
            state <= lsu_pkg::ld_done;
          end
        end
        lsu_pkg::ld_done: begin
          state <= lsu_pkg::ld_accept;
        end
        default: begin
          state <= lsu_pkg::ld_accept;
        end
      endcase
    end
  end

  // Raw word for the output stage, forwarding first
  always_ff @(posedge clock) begin
    if (state == lsu_pkg::ld_accept && rvalid) begin
      lsu_rdata <= load_in_sq ? sq_wdata : l1d_data[addr_idx];
    end else if (state == lsu_pkg::ld_bus_wait && bus_rvalid) begin
      lsu_rdata <= bus_rdata;
    end
  end

  // Full-word store installs, partial hit invalidates
  assign store_upd = wvalid && ((w_full && w_cacheable) || w_hit);
  assign refill_upd = !wvalid && state == lsu_pkg::ld_bus_wait && bus_rvalid && cacheable;
  assign upd = store_upd || refill_upd;

  always_comb begin
    if (store_upd) begin
      upd_data = wdata;
      upd_valid = w_full;
      upd_tag = waddr_tag;
      upd_idx = waddr_idx;
    end else begin
      upd_data = bus_rdata;
      upd_valid = 1'b1;
      upd_tag = addr_tag;
      upd_idx = addr_idx;
    end
  end

  always_ff @(posedge clock) begin
    if (upd) begin
      l1d_data[upd_idx] <= upd_data;
      l1d_tag[upd_idx] <= upd_tag;
    end
  end

  // fence drops every line, even one being written
  always_ff @(posedge clock) begin
    if (reset || fence) begin
      l1d_valid <= '0;
    end else if (upd) begin
      l1d_valid[upd_idx] <= upd_valid;
    end
  end

endmodule

/* source/load_extend.sv */
`timescale 1ns/1ps

module load_extend (
  input  logic [lsu_pkg::xlen-1:0] lsu_rdata,
  input  logic                     lsu_rready,
  input  logic [4:0]               ralu,
  input  logic [1:0]               byte_offset,
  output logic [lsu_pkg::xlen-1:0] load_data,
  output logic                     load_done
);

  logic [lsu_pkg::xlen-1:0] shifted;

  // Addressed byte or halfword moves to lane 0
  assign shifted = lsu_rdata >> {byte_offset, 3'b000};

  always_comb begin
    case (ralu)
      lsu_pkg::alu_lb:  load_data = {{24{shifted[7]}}, shifted[7:0]};
      lsu_pkg::alu_lbu: load_data = {24'h000000, shifted[7:0]};
      lsu_pkg::alu_lh:  load_data = {{16{shifted[15]}}, shifted[15:0]};
      lsu_pkg::alu_lhu: load_data = {16'h0000, shifted[15:0]};
      lsu_pkg::alu_lw:  load_data = shifted;
      default:          load_data = shifted;
    endcase
  end

  assign load_done = lsu_rready;

endmodule

/* source/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       fence,
  input  logic                       load_valid,
  input  logic [lsu_pkg::xlen-1:0]   load_addr,
  input  logic [4:0]                 load_op,
  input  logic                       store_valid,
  input  logic [lsu_pkg::xlen-1:0]   store_addr,
  input  logic [lsu_pkg::xlen-1:0]   store_data,
  input  logic [4:0]                 store_op,
  input  logic                       bus_rvalid,
  input  logic [lsu_pkg::xlen-1:0]   bus_rdata,
  input  logic                       bus_bvalid,
  output logic [lsu_pkg::xlen-1:0]   load_data,
  output logic                       load_done,
  output logic                       sb_full,
  output logic                       bus_arvalid,
  output logic [lsu_pkg::xlen-1:0]   bus_araddr,
  output logic [lsu_pkg::xbytes-1:0] bus_rstrb,
  output logic                       bus_awvalid,
  output logic [lsu_pkg::xlen-1:0]   bus_awaddr,
  output logic [lsu_pkg::xlen-1:0]   bus_wdata,
  output logic [lsu_pkg::xbytes-1:0] bus_wstrb
);

  logic                     cache_wvalid;
  logic [lsu_pkg::xlen-1:0] cache_waddr;
  logic [lsu_pkg::xlen-1:0] cache_wdata;
  logic [4:0]               cache_wop;
  logic                     rvalid;
  logic                     load_in_sq;
  logic [lsu_pkg::xlen-1:0] sq_wdata;
  logic [lsu_pkg::xlen-1:0] lsu_rdata;
  logic                     lsu_rready;

  store_buffer store_buffer_i (
    .clock           (clock),
    .reset           (reset),
    .store_valid     (store_valid),
    .store_addr      (store_addr),
    .store_data      (store_data),
    .store_op        (store_op),
    .load_valid      (load_valid),
    .load_addr       (load_addr),
    .bus_bvalid      (bus_bvalid),
    .sb_full         (sb_full),
    .bus_awvalid     (bus_awvalid),
    .bus_awaddr      (bus_awaddr),
    .bus_wdata       (bus_wdata),
    .bus_wstrb       (bus_wstrb),
    .cache_wvalid    (cache_wvalid),
    .cache_waddr     (cache_waddr),
    .cache_wdata     (cache_wdata),
    .cache_wop       (cache_wop),
    .rvalid          (rvalid),
    .load_in_sq      (load_in_sq),
    .sq_wdata        (sq_wdata)
  );

  lsu_l1d lsu_l1d_i (
    .clock           (clock),
    .reset           (reset),
    .fence           (fence),
    .rvalid          (rvalid),
    .raddr           (load_addr),
    .ralu            (load_op),
    .load_in_sq      (load_in_sq),
    .sq_wdata        (sq_wdata),
    .wvalid          (cache_wvalid),
    .waddr           (cache_waddr),
    .wdata           (cache_wdata),
    .walu            (cache_wop),
    .bus_rvalid      (bus_rvalid),
    .bus_rdata       (bus_rdata),
    .lsu_rdata       (lsu_rdata),
    .lsu_rready      (lsu_rready),
    .bus_arvalid     (bus_arvalid),
    .bus_araddr      (bus_araddr),
    .bus_rstrb       (bus_rstrb)
  );

  load_extend load_extend_i (
    .lsu_rdata       (lsu_rdata),
    .lsu_rready      (lsu_rready),
    .ralu            (load_op),
    .byte_offset     (load_addr[1:0]),
    .load_data       (load_data),
    .load_done       (load_done)
  );

endmodule

/* verification/lsu_assertions.sv */
`timescale 1ns/1ps

module lsu_assertions (
  input logic                     clock,
  input logic                     reset,
  input logic                     rvalid,
  input logic                     load_in_sq,
  input logic                     load_done,
  input logic                     sb_full,
  input logic                     bus_arvalid,
  input logic [lsu_pkg::xlen-1:0] bus_araddr,
  input logic                     bus_rvalid,
  input logic                     bus_awvalid,
  input logic [lsu_pkg::xlen-1:0] bus_awaddr,
  input logic [lsu_pkg::xlen-1:0] bus_wdata,
  input logic                     bus_bvalid
);

  int   failures;
  logic idle_sample;

  // Load seen by the FSM while it sits in accept
  assign idle_sample = rvalid && !bus_arvalid && !load_done;

  reset_state: assert property (@(posedge clock)
    reset |=> !load_done && !bus_arvalid && !bus_awvalid && !sb_full)
    else begin
      $error("Outputs not idle after reset");
      failures++;
    end

  // Hit or forward finishes next cycle, a miss goes to the bus
  load_path: assert property (@(posedge clock) disable iff (reset)
    idle_sample |=> load_done != bus_arvalid)
    else begin
      $error("Load sampled in idle neither finished nor read the bus");
      failures++;
    end

  forward_latency: assert property (@(posedge clock) disable iff (reset)
    idle_sample && load_in_sq |=> load_done)
    else begin
      $error("Forwarded load did not finish in one cycle");
      failures++;
    end

  miss_latency: assert property (@(posedge clock) disable iff (reset)
    bus_arvalid && bus_rvalid |=> load_done)
    else begin
      $error("Load did not finish one cycle after the read response");
      failures++;
    end

  ar_hold: assert property (@(posedge clock) disable iff (reset)
    bus_arvalid && !bus_rvalid |=> bus_arvalid && $stable(bus_araddr))
    else begin
      $error("Read request dropped or changed before its response");
      failures++;
    end

  aw_hold: assert property (@(posedge clock) disable iff (reset)
    bus_awvalid && !bus_bvalid |=> bus_awvalid && $stable(bus_awaddr) && $stable(bus_wdata))
    else begin
      $error("Write request dropped or changed before its response");
      failures++;
    end

  done_pulse: assert property (@(posedge clock) disable iff (reset)
    load_done |=> !load_done)
    else begin
      $error("load_done stayed high for more than one cycle");
      failures++;
    end

endmodule

bind lsu_top lsu_assertions lsu_assertions_i (
  .clock       (clock),
  .reset       (reset),
  .rvalid      (rvalid),
  .load_in_sq  (load_in_sq),
  .load_done   (load_done),
  .sb_full     (sb_full),
  .bus_arvalid (bus_arvalid),
  .bus_araddr  (bus_araddr),
  .bus_rvalid  (bus_rvalid),
  .bus_awvalid (bus_awvalid),
  .bus_awaddr  (bus_awaddr),
  .bus_wdata   (bus_wdata),
  .bus_bvalid  (bus_bvalid)
);

/* verification/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;

  localparam int clock_period = 20;
  localparam int reset_cycles = 5;
  localparam int random_ops = 64;
  localparam int directed_ops = 56;
  // Four queued stores draining, then a slow bus read
  localparam int worst_op_cycles = 4 * 6 + 6;
  localparam int cycle_limit = reset_cycles + 2 * (random_ops + directed_ops) * worst_op_cycles;
  localparam int use_any = 0;
  localparam int no_read = 1;
  localparam int must_read = 2;
  localparam logic [31:0] cbase = lsu_pkg::cacheable_base;
  localparam logic [31:0] ubase = 32'h0000_2000;

  logic        clock;
  logic        reset;
  logic        fence;
  logic        load_valid;
  logic [31:0] load_addr;
  logic [4:0]  load_op;
  logic        store_valid;
  logic [31:0] store_addr;
  logic [31:0] store_data;
  logic [4:0]  store_op;
  logic        bus_rvalid;
  logic [31:0] bus_rdata;
  logic        bus_bvalid;
  logic [31:0] load_data;
  logic        load_done;
  logic        sb_full;
  logic        bus_arvalid;
  logic [31:0] bus_araddr;
  logic [3:0]  bus_rstrb;
  logic        bus_awvalid;
  logic [31:0] bus_awaddr;
  logic [31:0] bus_wdata;
  logic [3:0]  bus_wstrb;

  integer seed = 79390;
  int     cycles = 0;
  int     data_errors = 0;
  int     timeouts = 0;

  // Bus side memory and the core's view of it
  logic [31:0] mem_words [logic [29:0]];
  logic [31:0] shadow_words [logic [29:0]];

  lsu_top lsu_top_i (.*);

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  function automatic logic [31:0] fill_word(input logic [29:0] word);
    return {word[13:0], word[29:12]} ^ 32'h5a3c_96e1;
  endfunction

  function automatic logic [31:0] memory_word(input logic [29:0] word);
    if (mem_words.exists(word)) return mem_words[word];
    return fill_word(word);
  endfunction

  function automatic logic [31:0] shadow_word(input logic [29:0] word);
    if (shadow_words.exists(word)) return shadow_words[word];
    return fill_word(word);
  endfunction

  function automatic int draw_latency();
    return 1 + (($random(seed) & 32'h7fff_ffff) % 4);
  endfunction

  function automatic logic [31:0] expect_load(input logic [31:0] addr, input logic [4:0] op);
    logic [31:0] word;
    logic [7:0]  byte_val;
    logic [15:0] half_val;
    word = shadow_word(addr[31:2]);
    byte_val = word[{addr[1:0], 3'b000} +: 8];
    half_val = word[{addr[1], 4'b0000} +: 16];
    case (op)
      lsu_pkg::alu_lb:  return {{24{byte_val[7]}}, byte_val};
      lsu_pkg::alu_lbu: return {24'h000000, byte_val};
      lsu_pkg::alu_lh:  return {{16{half_val[15]}}, half_val};
      lsu_pkg::alu_lhu: return {16'h0000, half_val};
      default:          return word;
    endcase
  endfunction

  // Random pick over two conflicting cacheable blocks and one uncacheable block
  function automatic logic [31:0] random_addr(input logic [3:0] pick, input logic [1:0] offset);
    if (!pick[3]) return cbase + 32'h100 + {pick[2:0], offset};
    if (!pick[2]) return cbase + 32'h140 + {pick[1:0], offset};
    return ubase + {pick[1:0], offset};
  endfunction

  // Memory model, answers after 1 to 4 cycles
  initial begin : memory_model
    int rd_left;
    int wr_left;
    logic [31:0] word;
    rd_left = 0;
    wr_left = 0;
    bus_rvalid = 1'b0;
    bus_rdata = '0;
    bus_bvalid = 1'b0;
    forever begin
      @(negedge clock);
      if (bus_rvalid) begin
        bus_rvalid = 1'b0;
      end else if (bus_arvalid) begin
        if (rd_left == 0) rd_left = draw_latency();
        rd_left--;
        if (rd_left == 0) begin
          word = memory_word(bus_araddr[31:2]);
          // Lanes outside the read strobe come back inverted
          for (int i = 0; i < 4; i++) begin
            if (!bus_rstrb[i]) word[i*8 +: 8] = ~word[i*8 +: 8];
          end
          bus_rdata = word;
          bus_rvalid = 1'b1;
        end
      end
      if (bus_bvalid) begin
        bus_bvalid = 1'b0;
      end else if (bus_awvalid) begin
        if (wr_left == 0) wr_left = draw_latency();
        wr_left--;
        if (wr_left == 0) begin
          word = memory_word(bus_awaddr[31:2]);
          for (int i = 0; i < 4; i++) begin
            if (bus_wstrb[i]) word[i*8 +: 8] = bus_wdata[i*8 +: 8];
          end
          mem_words[bus_awaddr[31:2]] = word;
          bus_bvalid = 1'b1;
        end
      end
    end
  end

  task automatic push_store(input logic [31:0] addr, input logic [31:0] data,
                            input logic [4:0] op);
    logic [31:0] word;
    while (sb_full) @(negedge clock);
    word = shadow_word(addr[31:2]);
    case (op)
      lsu_pkg::alu_sb: word[{addr[1:0], 3'b000} +: 8] = data[7:0];
      lsu_pkg::alu_sh: word[{addr[1], 4'b0000} +: 16] = data[15:0];
      default:         word = data;
    endcase
    shadow_words[addr[31:2]] = word;
    store_valid = 1'b1;
    store_addr = addr;
    store_data = data;
    store_op = op;
    @(negedge clock);
    store_valid = 1'b0;
  endtask

  task automatic run_load(input logic [31:0] addr, input logic [4:0] op, input int bus_use);
    logic [31:0] expected;
    logic        saw_read;
    expected = expect_load(addr, op);
    saw_read = 1'b0;
    load_valid = 1'b1;
    load_addr = addr;
    load_op = op;
    do begin
      @(negedge clock);
      saw_read |= bus_arvalid;
    end while (!load_done);
    data_check: assert (load_data == expected) else begin
      $display("** Error: load_data at %h expected %h actual %h", addr, expected, load_data);
      data_errors++;
    end
    if (bus_use == no_read && saw_read) begin
      $display("Load at %h read the bus although a hit or forward was expected", addr);
      data_errors++;
    end else if (bus_use == must_read && !saw_read) begin
      $display("Load at %h finished without reading the bus", addr);
      data_errors++;
    end
    load_valid = 1'b0;
  endtask

  task automatic pulse_fence();
    fence = 1'b1;
    @(negedge clock);
    fence = 1'b0;
  endtask

  task automatic report_and_finish();
    int assert_errors;
    assert_errors = lsu_top_i.lsu_assertions_i.failures;
    $display("Run ended after %0d cycles: %0d data errors, %0d timeouts, %0d assertion failures",
             cycles, data_errors, timeouts, assert_errors);
    if (data_errors + timeouts + assert_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      timeouts++;
      report_and_finish();
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] data;
    reset = 1'b1;
    fence = 1'b0;
    load_valid = 1'b0;
    load_addr = '0;
    load_op = lsu_pkg::alu_lw;
    store_valid = 1'b0;
    store_addr = '0;
    store_data = '0;
    store_op = lsu_pkg::alu_sw;
    repeat (reset_cycles) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);

    // Miss, hit, then a conflict on the same index
    run_load(cbase + 32'h100, lsu_pkg::alu_lw, must_read);
    run_load(cbase + 32'h100, lsu_pkg::alu_lw, no_read);
    run_load(cbase + 32'h140, lsu_pkg::alu_lw, must_read);
    run_load(cbase + 32'h100, lsu_pkg::alu_lw, must_read);

    for (int i = 0; i < 8; i++) begin
      run_load(ubase + 4 * (i % 4), lsu_pkg::alu_lw, must_read);
    end

    // Fresh word, so only forwarding avoids the bus
    push_store(cbase + 32'h108, 32'hdead_beef, lsu_pkg::alu_sw);
    run_load(cbase + 32'h108, lsu_pkg::alu_lw, no_read);

    // Partial store hit drops the line
    run_load(cbase + 32'h104, lsu_pkg::alu_lw, must_read);
    run_load(cbase + 32'h104, lsu_pkg::alu_lw, no_read);
    push_store(cbase + 32'h105, 32'h0000_005c, lsu_pkg::alu_sb);
    run_load(cbase + 32'h104, lsu_pkg::alu_lw, must_read);
    push_store(ubase + 32'h2, 32'h0000_c3a7, lsu_pkg::alu_sh);
    run_load(ubase, lsu_pkg::alu_lw, must_read);

    // Every legal byte and halfword offset
    push_store(cbase + 32'h10c, 32'h80f1_7f8e, lsu_pkg::alu_sw);
    push_store(ubase + 32'h10, 32'h7e01_ff80, lsu_pkg::alu_sw);
    for (int off = 0; off < 4; off++) begin
      run_load(cbase + 32'h10c + off, lsu_pkg::alu_lb, use_any);
      run_load(cbase + 32'h10c + off, lsu_pkg::alu_lbu, use_any);
      run_load(ubase + 32'h10 + off, lsu_pkg::alu_lb, must_read);
      run_load(ubase + 32'h10 + off, lsu_pkg::alu_lbu, must_read);
    end
    for (int off = 0; off < 4; off += 2) begin
      run_load(cbase + 32'h10c + off, lsu_pkg::alu_lh, use_any);
      run_load(cbase + 32'h10c + off, lsu_pkg::alu_lhu, use_any);
    end

    run_load(cbase + 32'h10c, lsu_pkg::alu_lw, no_read);
    pulse_fence();
    run_load(cbase + 32'h10c, lsu_pkg::alu_lw, must_read);
    run_load(cbase + 32'h10c, lsu_pkg::alu_lw, no_read);

    // Burst fills the buffer
    for (int i = 0; i < 6; i++) begin
      push_store(ubase + 32'h20 + 4 * i, 32'h1000_0001 * (i + 1), lsu_pkg::alu_sw);
    end
    run_load(ubase + 32'h20, lsu_pkg::alu_lw, must_read);

    for (int i = 0; i < random_ops; i++) begin
      r = $random(seed);
      data = $random(seed);
      case (r[2:0])
        3'd0: push_store(random_addr(r[6:3], 2'b00), data, lsu_pkg::alu_sw);
        3'd1: push_store(random_addr(r[6:3], {r[7], 1'b0}), data, lsu_pkg::alu_sh);
        3'd2: push_store(random_addr(r[6:3], r[8:7]), data, lsu_pkg::alu_sb);
        3'd3: run_load(random_addr(r[6:3], 2'b00), lsu_pkg::alu_lw, use_any);
        3'd4: run_load(random_addr(r[6:3], {r[7], 1'b0}), lsu_pkg::alu_lh, use_any);
        3'd5: run_load(random_addr(r[6:3], {r[7], 1'b0}), lsu_pkg::alu_lhu, use_any);
        3'd6: run_load(random_addr(r[6:3], r[8:7]), lsu_pkg::alu_lb, use_any);
        default: run_load(random_addr(r[6:3], r[8:7]), lsu_pkg::alu_lbu, use_any);
      endcase
    end

    while (bus_awvalid || sb_full) @(negedge clock);
    repeat (4) @(negedge clock);
    report_and_finish();
  end

endmodule

/* sources.f */
source/lsu_pkg.sv
source/store_buffer.sv
source/lsu_l1d.sv
source/load_extend.sv
source/lsu_top.sv
verification/lsu_assertions.sv
verification/lsu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb \
  -f sources.f --Mdir "$build_dir" -o lsu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"$build_dir/lsu_sim" +verilator+error+limit+1000 > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$log_file"; then
  exit 0
fi
echo "Pass line not found in $log_file"
exit 1
